/* logic/fetch_if_pkg.sv */
/*
 * fetch interface types
 * branch kinds, the backend training record, the per-slot prediction
 * and the two-slot fetch packet handed to the fetch pipeline
 */
package fetch_if_pkg;

    // branch kind as stored in the btb and reported by the backend
    typedef enum logic [1:0] {
        br_normal = 2'b00, // conditional
        br_jump   = 2'b01, // direct or indirect jump
        br_call   = 2'b10,
        br_ret    = 2'b11
    } br_type_e;

    // one training record from the backend
    typedef struct packed {
        logic        update;    // record is live this cycle
        logic [31:0] pc;        // pc[2] picks the bank
        logic [31:0] target_pc;
        br_type_e    br_type;
        logic        is_branch;
        logic        taken;     // resolved direction
        logic [3:0]  history;   // local history seen at predict time
        logic [1:0]  scnt;      // counter seen at predict time
        logic        type_miss; // fresh entry, history restarts
    } correct_info_t;

    typedef struct packed {
        logic [31:0] target_pc;   // btb target or ras top
        logic [31:0] next_pc;     // fall-through when not taken
        br_type_e    br_type;
        logic        is_branch;   // btb hit
        logic        taken;
        logic [1:0]  scnt;
        logic [3:0]  history;
        logic        need_update; // btb miss
    } predict_info_t;

    typedef struct packed {
        logic [31:0]         pc;   // 8-byte packet, pc[2] set means slot 1 only
        logic [1:0]          mask; // slot valid
        predict_info_t [1:0] pred;
    } fetch_pkt_t;

endpackage

/* logic/bpu_cfg_pkg.sv */
/*
 * branch predictor configuration
 * default table sizes, btb entry layout and the reset fetch address
 */
package bpu_cfg_pkg;

    // btb tag taken from pc[21:12]
    localparam int tag_len = 10;

    // defaults for the top-level parameters
    localparam int btb_depth_def   = 64; // entries per bank
    localparam int hist_len_def    = 4;  // local history bits
    localparam int pht_pc_bits_def = 4;  // pc bits in the pattern index
    localparam int ras_depth_def   = 8;

    // first fetch after reset
    localparam logic [31:0] init_pc = 32'h1c00_0000;

    // one btb entry, 48 bits
    typedef struct packed {
        logic                   valid;     // holds a branch
        logic [tag_len-1:0]     tag;
        logic [31:0]            target_pc;
        fetch_if_pkg::br_type_e br_type;
        logic                   is_call;
        logic                   is_ret;    // target comes from the ras
        logic                   is_uncond; // taken regardless of counter
    } btb_entry_t;

endpackage

/* logic/bpu_btb.sv */
`timescale 1ns/100ps
/*
 * branch target buffer
 * two banks, one per fetch slot, each a tagged table with a
 * registered read port and a write port shared between the banks
 */
module bpu_btb #(
    parameter int  DEPTH = 64,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic                          clk,
    input  logic [IDX_W-1:0]              raddr_i,  // hashed from pc_next
    output bpu_cfg_pkg::btb_entry_t [1:0] rdata_o,  // lines up with pc_q
    input  logic [1:0]                    we_i,     // one bit per bank
    input  logic [IDX_W-1:0]              waddr_i,
    input  bpu_cfg_pkg::btb_entry_t       wdata_i
);

    for (genvar b = 0; b < 2; b++) begin : g_bank
        bpu_cfg_pkg::btb_entry_t mem [DEPTH];
        bpu_cfg_pkg::btb_entry_t rd_q;

        // write port
        always_ff @(posedge clk) begin
            if (we_i[b]) begin
                mem[waddr_i] <= wdata_i;
            end
        end

        // registered read, old data on a same-cycle write
        always_ff @(posedge clk) begin
            rd_q <= mem[raddr_i];
        end

        assign rdata_o[b] = rd_q;
    end

endmodule

/* logic/bpu_dir_pred.sv */
`timescale 1ns/100ps
/*
 * local-history direction predictor
 * per slot a history table indexed like the btb feeds a table of
 * 2-bit saturating counters indexed by {history, pc bits};
 * corrections update both, init mode writes zeros
 */
module bpu_dir_pred #(
    parameter int  HIST_LEN = 4,
    parameter int  PC_BITS  = 4,
    parameter int  DEPTH    = 64,
    localparam int IDX_W    = $clog2(DEPTH),
    localparam int PAT_W    = HIST_LEN + PC_BITS
) (
    input  logic                        clk,
    input  logic [IDX_W-1:0]            raddr_i,    // same index as the btb read
    input  logic [31:0]                 fetch_pc_i, // pc_q
    input  logic [1:0]                  upd_we_i,
    input  logic [IDX_W-1:0]            upd_addr_i,
    input  fetch_if_pkg::correct_info_t correct_i,
    input  logic                        init_i,     // clear sweep running
    output logic [1:0][HIST_LEN-1:0]    history_o,
    output logic [1:0][1:0]             scnt_o
);

    logic [IDX_W-1:0]    raddr_q;
    logic [HIST_LEN-1:0] hist_wdata;
    logic [1:0]          scnt_wdata;
    logic [PAT_W-1:0]    pat_waddr;

    // saturating step toward the resolved direction
    function automatic logic [1:0] next_scnt(input logic [1:0] cur, input logic taken);
        if (taken) begin
            return (cur == 2'b11) ? cur : cur + 2'd1;
        end
        return (cur == 2'b00) ? cur : cur - 2'd1;
    endfunction

    always_ff @(posedge clk) begin
        raddr_q <= raddr_i; // history read lines up with pc_q
    end

    always_comb begin
        if (init_i) begin
            hist_wdata = '0;
        end else if (correct_i.type_miss) begin
            hist_wdata = {HIST_LEN{correct_i.taken}}; // new entry, fill with outcome
        end else begin
            hist_wdata = {correct_i.history[HIST_LEN-2:0], correct_i.taken};
        end
    end

    assign scnt_wdata = init_i ? 2'b00 : next_scnt(correct_i.scnt, correct_i.taken);
    // counter written where it was read at predict time
    assign pat_waddr  = {correct_i.history[HIST_LEN-1:0], correct_i.pc[PC_BITS+2:3]};

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [HIST_LEN-1:0] bht [DEPTH];
        logic [1:0]          pht [2**PAT_W];
        logic [PAT_W-1:0]    pat_raddr;

        always_ff @(posedge clk) begin
            if (upd_we_i[b]) begin
                bht[upd_addr_i] <= hist_wdata;
                pht[pat_waddr]  <= scnt_wdata;
            end
        end

        assign history_o[b] = bht[raddr_q];
        assign pat_raddr    = {history_o[b], fetch_pc_i[PC_BITS+2:3]}; // both slots share pc bits
        assign scnt_o[b]    = pht[pat_raddr];
    end

endmodule

/* logic/bpu_ras.sv */
`timescale 1ns/100ps
/*
 * return address stack
 * upward-growing circular stack, push wins over pop,
 * overflow overwrites the oldest entry
 */
module bpu_ras #(
    parameter int  DEPTH = 8,
    localparam int PTR_W = $clog2(DEPTH)
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        push_i,
    input  logic [31:0] push_addr_i, // return address, call pc + 4
    input  logic        pop_i,
    output logic [31:0] top_o
);

    logic [31:0]      stack_q [DEPTH];
    logic [PTR_W-1:0] top_ptr_q; // current top
    logic [PTR_W-1:0] wr_ptr_q;  // slot above the top

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_q[wr_ptr_q] <= push_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            top_ptr_q <= '1; // empty
            wr_ptr_q  <= '0;
        end else if (push_i) begin
            top_ptr_q <= wr_ptr_q;
            wr_ptr_q  <= wr_ptr_q + 1'b1; // wraps onto oldest
        end else if (pop_i) begin
            wr_ptr_q  <= top_ptr_q;
            top_ptr_q <= top_ptr_q - 1'b1;
        end
    end

    assign top_o = stack_q[top_ptr_q]; // combinational to the pc logic

endmodule

/* logic/bpu.sv */
`timescale 1ns/100ps
/*
 * fetch-stage branch predictor
 * pc register, table init sweep, next-pc priority and slot mask for
 * two-instruction fetch packets sent on a valid/ready handshake;
 * trained from one backend correction port
 */
module bpu #(
    parameter int BTB_DEPTH   = bpu_cfg_pkg::btb_depth_def,
    parameter int HIST_LEN    = bpu_cfg_pkg::hist_len_def,
    parameter int PHT_PC_BITS = bpu_cfg_pkg::pht_pc_bits_def,
    parameter int RAS_DEPTH   = bpu_cfg_pkg::ras_depth_def
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  logic [31:0]                 redir_addr_i,
    input  fetch_if_pkg::correct_info_t correct_i,
    output logic                        fetch_valid_o,
    input  logic                        fetch_ready_i,
    output fetch_if_pkg::fetch_pkt_t    fetch_pkt_o
);

    localparam int BTB_IDX_W = $clog2(BTB_DEPTH);
    localparam int PHT_IDX_W = HIST_LEN + PHT_PC_BITS; // sweep covers the pattern table
    localparam int TAG_LEN   = bpu_cfg_pkg::tag_len;

    logic [31:0]                   pc_q;
    logic [31:0]                   pc_next;
    logic [31:0]                   pc_seq0;    // slot 1 address
    logic [31:0]                   pc_seq8;    // next aligned packet
    logic                          init_busy_q;
    logic [PHT_IDX_W-1:0]          sweep_cnt_q;
    logic                          xfer;
    fetch_if_pkg::correct_info_t   upd_rec;    // correction or sweep record
    logic [1:0]                    upd_we;
    logic [BTB_IDX_W-1:0]          rd_idx;
    logic [BTB_IDX_W-1:0]          wr_idx;
    bpu_cfg_pkg::btb_entry_t [1:0] btb_rdata;
    bpu_cfg_pkg::btb_entry_t       btb_wdata;
    logic [1:0][HIST_LEN-1:0]      hist;
    logic [1:0][1:0]               scnt;
    logic [1:0]                    hit;
    logic [1:0]                    taken;
    logic [1:0]                    mask;
    logic [1:0]                    push_slot;
    logic [1:0]                    pop_slot;
    logic [1:0][31:0]              target;
    logic [1:0][31:0]              npc;
    logic [31:0]                   ras_top;

    // pc[17:9] ^ pc[11:3] folded down to the index width
    function automatic logic [BTB_IDX_W-1:0] btb_hash(input logic [31:0] pc);
        logic [8:0]           h;
        logic [BTB_IDX_W-1:0] idx;
        h   = pc[17:9] ^ pc[11:3];
        idx = '0;
        for (int k = 0; k < 9; k++) begin
            idx[k % BTB_IDX_W] ^= h[k];
        end
        return idx;
    endfunction

    // init sweep clears one table row per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            init_busy_q <= 1'b1;
            sweep_cnt_q <= '0;
        end else if (init_busy_q) begin
            sweep_cnt_q <= sweep_cnt_q + 1'b1;
            if (&sweep_cnt_q) begin
                init_busy_q <= 1'b0; // last row written
            end
        end
    end

    assign fetch_valid_o = ~init_busy_q;
    assign xfer          = fetch_valid_o & fetch_ready_i;

    // sweep record walks every {history, pc bits} pattern index
    always_comb begin
        upd_rec = correct_i;
        if (init_busy_q) begin
            upd_rec = '0;
            upd_rec.history[HIST_LEN-1:0]  = sweep_cnt_q[PHT_IDX_W-1:PHT_PC_BITS];
            upd_rec.pc[PHT_PC_BITS+2:3]    = sweep_cnt_q[PHT_PC_BITS-1:0];
        end
    end

    assign upd_we = init_busy_q ? 2'b11 :
                    {2{correct_i.update}} & {correct_i.pc[2], ~correct_i.pc[2]};
    assign wr_idx = init_busy_q ? sweep_cnt_q[BTB_IDX_W-1:0] : btb_hash(correct_i.pc);
    assign rd_idx = btb_hash(pc_next); // sync read so data meets pc_q

    always_comb begin
        btb_wdata = '0; // sweep writes empty entries
        if (!init_busy_q) begin
            btb_wdata.valid     = correct_i.is_branch;
            btb_wdata.tag       = correct_i.pc[TAG_LEN+11:12];
            btb_wdata.target_pc = correct_i.target_pc;
            btb_wdata.br_type   = correct_i.br_type;
            btb_wdata.is_call   = correct_i.br_type == fetch_if_pkg::br_call;
            btb_wdata.is_ret    = correct_i.br_type == fetch_if_pkg::br_ret;
            btb_wdata.is_uncond = correct_i.br_type != fetch_if_pkg::br_normal;
        end
    end

    bpu_btb #(
        .DEPTH (BTB_DEPTH)
    ) u_btb (
        .clk     (clk),
        .raddr_i (rd_idx),
        .rdata_o (btb_rdata),
        .we_i    (upd_we),
        .waddr_i (wr_idx),
        .wdata_i (btb_wdata)
    );

    bpu_dir_pred #(
        .HIST_LEN (HIST_LEN),
        .PC_BITS  (PHT_PC_BITS),
        .DEPTH    (BTB_DEPTH)
    ) u_dir_pred (
        .clk        (clk),
        .raddr_i    (rd_idx),
        .fetch_pc_i (pc_q),
        .upd_we_i   (upd_we),
        .upd_addr_i (wr_idx),
        .correct_i  (upd_rec),
        .init_i     (init_busy_q),
        .history_o  (hist),
        .scnt_o     (scnt)
    );

    bpu_ras #(
        .DEPTH (RAS_DEPTH)
    ) u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (xfer & (|push_slot)),
        .push_addr_i (push_slot[0] ? pc_seq0 : pc_seq8), // address after the call
        .pop_i       (xfer & (|pop_slot)),
        .top_o       (ras_top)
    );

    assign pc_seq0 = {pc_q[31:3], 3'b100};
    assign pc_seq8 = {pc_q[31:3] + 29'd1, 3'b000};

    assign mask[0] = ~pc_q[2];
    assign mask[1] = pc_q[2] | ~taken[0]; // shadowed by a taken slot 0

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign hit[i]       = btb_rdata[i].valid && (btb_rdata[i].tag == pc_q[TAG_LEN+11:12]);
        assign taken[i]     = hit[i] && (btb_rdata[i].is_uncond || scnt[i][1]);
        assign target[i]    = btb_rdata[i].is_ret ? ras_top : btb_rdata[i].target_pc;
        assign push_slot[i] = mask[i] && taken[i] && btb_rdata[i].is_call;
        assign pop_slot[i]  = mask[i] && taken[i] && btb_rdata[i].is_ret;
    end

    assign npc[0] = taken[0] ? target[0] : pc_seq0;
    assign npc[1] = taken[1] ? target[1] : pc_seq8;

    always_comb begin
        if (flush_i) begin
            pc_next = redir_addr_i;
        end else if (!xfer) begin
            pc_next = pc_q; // hold so tables re-read the same row
        end else if (taken[0] && !pc_q[2]) begin
            pc_next = target[0];
        end else if (taken[1]) begin
            pc_next = target[1];
        end else begin
            pc_next = pc_seq8;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= bpu_cfg_pkg::init_pc;
        end else begin
            pc_q <= pc_next;
        end
    end

    always_comb begin
        fetch_pkt_o.pc   = pc_q;
        fetch_pkt_o.mask = mask;
        for (int i = 0; i < 2; i++) begin
            fetch_pkt_o.pred[i].target_pc   = target[i];
            fetch_pkt_o.pred[i].next_pc     = npc[i];
            fetch_pkt_o.pred[i].br_type     = btb_rdata[i].br_type;
            fetch_pkt_o.pred[i].is_branch   = hit[i];
            fetch_pkt_o.pred[i].taken       = taken[i];
            fetch_pkt_o.pred[i].scnt        = scnt[i];
            fetch_pkt_o.pred[i].history     = 4'(hist[i]);
            fetch_pkt_o.pred[i].need_update = ~hit[i]; // miss so the backend allocates
        end
    end

endmodule

/* testbench/bpu_properties.sv */
`timescale 1ns/100ps
/*
 * bpu handshake and reset properties
 * bound onto bpu, checks reset, valid and back-pressure behavior
 */
module bpu_properties (
    input logic                     clk,
    input logic                     rst,
    input logic                     flush_i,
    input logic                     fetch_valid_o,
    input logic                     fetch_ready_i,
    input fetch_if_pkg::fetch_pkt_t fetch_pkt_o
);

    // reset always leaves the fetch port idle
    a_rst_invalid: assert property (@(posedge clk) rst |=> !fetch_valid_o)
        else $error("fetch valid high right after reset");

    // pc holds under back-pressure unless redirected
    a_hold_pc: assert property (@(posedge clk) disable iff (rst)
        fetch_valid_o && !fetch_ready_i && !flush_i |=> $stable(fetch_pkt_o.pc))
        else $error("packet pc moved while ready was low");

    // once the sweep is done valid never drops
    a_valid_sticky: assert property (@(posedge clk) disable iff (rst)
        fetch_valid_o |=> fetch_valid_o)
        else $error("fetch valid dropped after the init sweep");

endmodule

/* testbench/tb_bpu_checker.sv */
`timescale 1ns/100ps
/*
 * fetch port checker
 * counts the init sweep, compares accepted packets with the armed
 * expectation and watches packets held under back-pressure
 */
module tb_bpu_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetch_valid_i,
    input  logic                     fetch_ready_i,
    input  logic                     hold_chk_i,  // stall row running
    input  fetch_if_pkg::fetch_pkt_t pkt_i,
    output int                       err_cnt_o,
    output int                       chk_cnt_o
);

    // pattern table rows written one per sweep cycle
    localparam int sweep_len = 2 ** (bpu_cfg_pkg::hist_len_def + bpu_cfg_pkg::pht_pc_bits_def);

    string                    nm;
    logic                     armed = 1'b0;
    logic [31:0]              e_pc;
    logic [31:0]              e_npc;
    logic [1:0]               e_mask;
    logic [1:0]               e_taken;
    int                       sweep_cyc;
    logic                     seen_valid;
    logic                     hold_q = 1'b0;
    fetch_if_pkg::fetch_pkt_t pkt_q;
    int                       sel;

    initial begin
        err_cnt_o = 0;
        chk_cnt_o = 0;
    end

    // called by the driver when it raises ready
    task automatic arm(input string name, input logic [31:0] pc, input logic [1:0] mask,
                       input logic [1:0] taken, input logic [31:0] npc);
        nm      = name;
        e_pc    = pc;
        e_mask  = mask;
        e_taken = taken;
        e_npc   = npc;
        armed   = 1'b1;
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt_o++;
        if (exp !== act) begin
            err_cnt_o++;
            $display("[ERROR] %s %s expected %h actual %h", nm, what, exp, act);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            sweep_cyc  = 0;
            seen_valid = 1'b0;
        end else begin
            if (!seen_valid) begin
                if (fetch_valid_i) begin
                    seen_valid = 1'b1;
                    nm         = "reset_sweep";
                    check_val("sweep cycles", sweep_len, sweep_cyc);
                end else begin
                    sweep_cyc++; // still clearing tables
                end
            end
            if (armed) begin
                armed = 1'b0;
                if (!(fetch_valid_i && fetch_ready_i)) begin
                    err_cnt_o++;
                    $display("[ERROR] %s: no packet was accepted", nm);
                end else begin
                    // last live slot decides where fetch goes next
                    sel = (e_mask[0] && e_taken[0]) ? 0 : 1;
                    check_val("pc", e_pc, pkt_i.pc);
                    check_val("mask", 32'(e_mask), 32'(pkt_i.mask));
                    check_val("taken", 32'(e_taken),
                              32'({pkt_i.pred[1].taken, pkt_i.pred[0].taken}));
                    check_val("next_pc", e_npc, pkt_i.pred[sel].next_pc);
                end
            end
            if (hold_chk_i && hold_q && fetch_valid_i) begin
                chk_cnt_o++;
                if (pkt_i !== pkt_q) begin
                    err_cnt_o++;
                    $display("[ERROR] stall packet expected %h actual %h", pkt_q, pkt_i);
                end
            end
        end
        hold_q = hold_chk_i;
        pkt_q  = pkt_i;
    end

endmodule

/* testbench/tb_bpu.sv */
`timescale 1ns/100ps
/*
 * testbench for the fetch-stage branch predictor
 * walks a table of rows (wait, train, flush, stall, expect) through bpu;
 * packet compares happen in tb_bpu_checker
 */
module tb_bpu;

    typedef enum logic [2:0] {
        act_wait_valid, act_correct, act_flush, act_stall, act_expect
    } act_e;

    typedef struct packed {
        act_e                   act;
        logic [31:0]            addr;  // training pc, flush target or expected pc
        logic [31:0]            tgt;   // trained target
        fetch_if_pkg::br_type_e bt;
        logic [3:0]             hist;  // history seen at predict time
        logic [1:0]             scnt;
        logic                   tmiss;
        logic [1:0]             mask;  // expected slot mask
        logic [1:0]             taken; // expected per-slot taken
        logic [31:0]            npc;   // expected next packet pc
    } row_t;

    localparam int n_rows     = 20;
    localparam int wd_cycles  = n_rows * 20 + 256 + 8;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        flush_i;
    logic [31:0]                 redir_addr_i;
    fetch_if_pkg::correct_info_t correct_i;
    logic                        fetch_valid_o;
    logic                        fetch_ready_i;
    fetch_if_pkg::fetch_pkt_t    fetch_pkt_o;
    logic                        hold_chk;
    int                          err_cnt;
    int                          chk_cnt;
    row_t                        rows [n_rows];
    string                       names [n_rows];

    initial begin
        forever #5 clk = ~clk; // 10 ns
    end

    bpu u_dut (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .redir_addr_i  (redir_addr_i),
        .correct_i     (correct_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_ready_i (fetch_ready_i),
        .fetch_pkt_o   (fetch_pkt_o)
    );

    tb_bpu_checker u_chk (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid_i (fetch_valid_o),
        .fetch_ready_i (fetch_ready_i),
        .hold_chk_i    (hold_chk),
        .pkt_i         (fetch_pkt_o),
        .err_cnt_o     (err_cnt),
        .chk_cnt_o     (chk_cnt)
    );

    bind bpu bpu_properties u_props (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_ready_i (fetch_ready_i),
        .fetch_pkt_o   (fetch_pkt_o)
    );

    task automatic set_row(input int i, input string name, input act_e act,
                           input logic [31:0] addr, input logic [31:0] tgt,
                           input fetch_if_pkg::br_type_e bt, input logic [3:0] hist,
                           input logic [1:0] scnt, input logic tmiss, input logic [1:0] mask,
                           input logic [1:0] taken, input logic [31:0] npc);
        names[i] = name;
        rows[i]  = '{act, addr, tgt, bt, hist, scnt, tmiss, mask, taken, npc};
    endtask

    // each trained branch sits in its own 4 KB page so tags never alias
    initial begin
        set_row(0, "reset_sweep", act_wait_valid, 0, 0, fetch_if_pkg::br_normal, 0, 0, 0, 0, 0, 0);
        set_row(1, "first_pkt", act_expect, 32'h1c00_0000, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 2'b11, 2'b00, 32'h1c00_0008);
        set_row(2, "seq_pkt", act_expect, 32'h1c00_0008, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 2'b11, 2'b00, 32'h1c00_0010);
        set_row(3, "stall", act_stall, 0, 0, fetch_if_pkg::br_normal, 0, 0, 0, 0, 0, 0);
        set_row(4, "after_stall", act_expect, 32'h1c00_0010, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 2'b11, 2'b00, 32'h1c00_0018);
        set_row(5, "flush_odd", act_flush, 32'h1c00_0104, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 0, 0, 0);
        set_row(6, "flush_pkt", act_expect, 32'h1c00_0104, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 2'b10, 2'b00, 32'h1c00_0108); // slot 1 only
        set_row(7, "train_jump", act_correct, 32'h1c00_2200, 32'h1c00_6400,
                fetch_if_pkg::br_jump, 4'h0, 2'd0, 1'b1, 0, 0, 0);
        set_row(8, "goto_jump", act_flush, 32'h1c00_2200, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 0, 0, 0);
        set_row(9, "jump_pkt", act_expect, 32'h1c00_2200, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 2'b01, 2'b01, 32'h1c00_6400); // slot 1 shadowed
        set_row(10, "jump_tgt", act_expect, 32'h1c00_6400, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 2'b11, 2'b00, 32'h1c00_6408);
        // counter 0 then 1 with both taken ends at 2
        set_row(11, "train_cond_0", act_correct, 32'h1c00_3600, 32'h1c00_3800,
                fetch_if_pkg::br_normal, 4'h0, 2'd0, 1'b1, 0, 0, 0);
        set_row(12, "train_cond_1", act_correct, 32'h1c00_3600, 32'h1c00_3800,
                fetch_if_pkg::br_normal, 4'hf, 2'd1, 1'b0, 0, 0, 0); // history after miss fill
        set_row(13, "goto_cond", act_flush, 32'h1c00_3600, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 0, 0, 0);
        set_row(14, "cond_pkt", act_expect, 32'h1c00_3600, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 2'b01, 2'b01, 32'h1c00_3800); // sibling slot untrained
        set_row(15, "train_call", act_correct, 32'h1c00_4a00, 32'h1c00_5c00,
                fetch_if_pkg::br_call, 4'h0, 2'd0, 1'b1, 0, 0, 0);
        set_row(16, "train_ret", act_correct, 32'h1c00_5c04, 32'h0,
                fetch_if_pkg::br_ret, 4'h0, 2'd0, 1'b1, 0, 0, 0);
        set_row(17, "goto_call", act_flush, 32'h1c00_4a00, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 0, 0, 0);
        set_row(18, "call_pkt", act_expect, 32'h1c00_4a00, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 2'b01, 2'b01, 32'h1c00_5c00);
        set_row(19, "ret_pkt", act_expect, 32'h1c00_5c00, 0, fetch_if_pkg::br_normal,
                0, 0, 0, 2'b11, 2'b10, 32'h1c00_4a04); // call pc + 4
    end

    // driver changes inputs on the falling edge only
    initial begin
        int stall_n;
        void'($urandom(32'h221a_74a3));
        rst           = 1'b1;
        flush_i       = 1'b0;
        redir_addr_i  = '0;
        correct_i     = '0;
        fetch_ready_i = 1'b0;
        hold_chk      = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            case (rows[i].act)
                act_wait_valid: begin
                    while (!fetch_valid_o) @(negedge clk);
                end
                act_correct: begin
                    correct_i.update    = 1'b1;
                    correct_i.pc        = rows[i].addr;
                    correct_i.target_pc = rows[i].tgt;
                    correct_i.br_type   = rows[i].bt;
                    correct_i.is_branch = 1'b1;
                    correct_i.taken     = 1'b1;
                    correct_i.history   = rows[i].hist;
                    correct_i.scnt      = rows[i].scnt;
                    correct_i.type_miss = rows[i].tmiss;
                    @(negedge clk);
                    correct_i = '0;
                end
                act_flush: begin
                    flush_i      = 1'b1;
                    redir_addr_i = rows[i].addr;
                    @(negedge clk);
                    flush_i = 1'b0;
                end
                act_stall: begin
                    stall_n  = 2 + int'($urandom % 7); // at least one held-packet compare
                    hold_chk = 1'b1;
                    repeat (stall_n) @(negedge clk);
                    hold_chk = 1'b0;
                end
                default: begin
                    u_chk.arm(names[i], rows[i].addr, rows[i].mask, rows[i].taken, rows[i].npc);
                    fetch_ready_i = 1'b1; // accept exactly one packet
                    @(negedge clk);
                    fetch_ready_i = 1'b0;
                end
            endcase
            @(negedge clk); // registered table reads catch up
            $display("[INFO] %s done", names[i]);
        end
        @(negedge clk);
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0 && chk_cnt > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // row budget plus sweep and reset
    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", wd_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* tb.f */
logic/fetch_if_pkg.sv
logic/bpu_cfg_pkg.sv
logic/bpu_btb.sv
logic/bpu_dir_pred.sv
logic/bpu_ras.sv
logic/bpu.sv
testbench/bpu_properties.sv
testbench/tb_bpu_checker.sv
testbench/tb_bpu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bpu testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_bpu -o tb_bpu \
    && ./obj_dir/tb_bpu > sim.log 2>&1 \
    || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
